//--- Bender.yml
package:
  name: exec_subsystem

sources:
  - files:
      - design/exec_pkg.sv
      - design/exec_alu.sv
      - design/exec_branch_unit.sv
      - design/exec_agu.sv
      - design/exec_divider.sv
      - design/execute_stage.sv
      - design/exec_top.sv
  - target: simulation
    files:
      - verif/exec_tb.sv

//--- design/exec_agu.sv
`timescale 1ns/1ps

module exec_agu
  import exec_pkg::*;
(
  input  word_t    rdata1,
  input  word_t    imm,
  input  word_t    pc,
  input  logic     auipc,
  input  logic     jalr,
  input  logic     branch,
  input  logic     jal,
  input  logic     load,
  input  logic     store,
  input  lsu_op_e  lsu_op,
  output word_t    address,
  output byte_en_t byte_enable,
  output logic     exception,
  output cause_t   ecause,
  output word_t    etval
);

  word_t    sum;
  byte_en_t mask;
  logic     mem_misaligned;

  assign sum = ((jal | branch | auipc) ? pc : rdata1) + imm;
  assign address = jalr ? {sum[31:1], 1'b0} : sum;
  assign etval = address;
  assign byte_enable = (load | store) ? mask : '0;

  always_comb begin
    case (lsu_op)
      lsu_lb, lsu_lbu, lsu_sb: begin
        mask = 4'b0001 << address[1:0];
        mem_misaligned = 1'b0;
      end
      lsu_lh, lsu_lhu, lsu_sh: begin
        mask = 4'b0011 << {address[1], 1'b0};
        mem_misaligned = address[0];
      end
      default: begin
        mask = 4'b1111;
        mem_misaligned = |address[1:0];
      end
    endcase
  end

  always_comb begin
    exception = 1'b0;
    ecause = cause_inst_misaligned;
    if (load | store) begin
      exception = mem_misaligned;
      ecause = load ? cause_load_misaligned : cause_store_misaligned;
    end else if (jal | jalr | branch) begin
      exception = |address[1:0]; // Targets must sit on a word boundary.
    end
  end

  a_single_access: assert final (!(load && store))
    else $error("Load and store requested by one instruction.");

endmodule

//--- design/exec_alu.sv
`timescale 1ns/1ps

module exec_alu
  import exec_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  logic [4:0] shamt;
  logic       less_signed;
  logic       less_unsigned;

  assign shamt = b[4:0]; // RV32 uses only the low five bits.
  assign less_signed = $signed(a) < $signed(b);
  assign less_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {31'b0, less_signed};
      end
      alu_sltu: begin
        result = {31'b0, less_unsigned};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = $signed(a) >>> shamt;
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- design/exec_branch_unit.sv
`timescale 1ns/1ps

module exec_branch_unit
  import exec_pkg::*;
(
  input  word_t   rdata1,
  input  word_t   rdata2,
  input  bcu_op_e op,
  output logic    taken
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal = rdata1 == rdata2;
  assign less_signed = $signed(rdata1) < $signed(rdata2);
  assign less_unsigned = rdata1 < rdata2;

  always_comb begin
    case (op)
      bcu_beq:  taken = equal;
      bcu_bne:  taken = !equal;
      bcu_blt:  taken = less_signed;
      bcu_bge:  taken = !less_signed;
      bcu_bltu: taken = less_unsigned;
      bcu_bgeu: taken = !less_unsigned;
      default:  taken = 1'b0; // Unused funct3 codes never branch.
    endcase
  end

endmodule

//--- design/exec_divider.sv
`timescale 1ns/1ps

module exec_divider
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  logic    abort,
  input  div_op_e op,
  input  word_t   dividend,
  input  word_t   divisor,
  output logic    ready,
  output word_t   result
);

  div_state_e  state;
  logic [5:0]  count;
  div_op_e     op_q;
  word_t       quot_q;
  word_t       rem_q;
  word_t       dvs_q;
  logic        neg_quot_q;
  logic        neg_rem_q;

  logic        is_signed;
  word_t       dividend_mag;
  word_t       divisor_mag;
  logic [32:0] trial;
  logic [32:0] diff;

  assign is_signed = (op == div_div) | (op == div_rem);
  assign dividend_mag = (is_signed & dividend[31]) ? -dividend : dividend;
  assign divisor_mag = (is_signed & divisor[31]) ? -divisor : divisor;

  assign trial = {rem_q, quot_q[31]};
  assign diff = trial - {1'b0, dvs_q}; // Bit 32 set means the trial fails.

  // ~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= div_idle;
      count <= '0;
    end else if (abort) begin
      state <= div_idle;
    end else begin
      case (state)
        div_idle: begin
          if (start) begin
            state <= div_run;
            count <= '0;
          end
        end
        div_run: begin
          count <= count + 6'd1;
          if (count == 6'(div_steps - 1)) begin
            state <= div_done;
          end
        end
        default: begin
          state <= div_idle;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (state == div_idle && start) begin
      op_q <= op;
      quot_q <= dividend_mag; // Dividend bits shift out as quotient bits shift in.
      rem_q <= '0;
      dvs_q <= divisor_mag;
      // A zero divisor leaves an all ones quotient, which must keep its sign.
      neg_quot_q <= is_signed & (dividend[31] ^ divisor[31]) & (|divisor);
      neg_rem_q <= is_signed & dividend[31];
    end else if (state == div_run) begin
      quot_q <= {quot_q[30:0], !diff[32]};
      rem_q <= diff[32] ? trial[31:0] : diff[31:0];
    end
  end

  // Overflow needs no special case since the magnitudes give 0x80000000 and 0.
  always_comb begin
    if (op_q == div_rem || op_q == div_remu) begin
      result = neg_rem_q ? -rem_q : rem_q;
    end else begin
      result = neg_quot_q ? -quot_q : quot_q;
    end
  end

  assign ready = state == div_done;

  a_start_idle: assert property (@(posedge clk) disable iff (!rst) start |-> state == div_idle)
    else $error("Divider started while not idle.");

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst) ready |=> !ready)
    else $error("Divider ready held longer than one cycle.");

endmodule

//--- design/exec_pkg.sv
package exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Word types
  // ~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [3:0]  cause_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Operation codes
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    bcu_beq  = 3'b000,
    bcu_bne  = 3'b001,
    bcu_blt  = 3'b100,
    bcu_bge  = 3'b101,
    bcu_bltu = 3'b110,
    bcu_bgeu = 3'b111
  } bcu_op_e;

  typedef enum logic [2:0] {
    lsu_lb  = 3'd0,
    lsu_lh  = 3'd1,
    lsu_lw  = 3'd2,
    lsu_lbu = 3'd3,
    lsu_lhu = 3'd4,
    lsu_sb  = 3'd5,
    lsu_sh  = 3'd6,
    lsu_sw  = 3'd7
  } lsu_op_e;

  typedef enum logic [1:0] {
    div_div  = 2'd0,
    div_divu = 2'd1,
    div_rem  = 2'd2,
    div_remu = 2'd3
  } div_op_e;

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_e;

  localparam cause_t cause_inst_misaligned  = 4'd0;
  localparam cause_t cause_load_misaligned  = 4'd4;
  localparam cause_t cause_store_misaligned = 4'd6;

  localparam int div_steps = 32; // One quotient bit per cycle.

endpackage

//--- design/exec_top.sv
`timescale 1ns/1ps

module exec_top
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue,
  input  word_t     pc,
  input  word_t     imm,
  input  word_t     rdata1,
  input  word_t     rdata2,
  input  reg_addr_t waddr,
  input  logic      rden2,
  input  logic      lui,
  input  logic      auipc,
  input  logic      jal,
  input  logic      jalr,
  input  logic      branch,
  input  logic      load,
  input  logic      store,
  input  logic      division,
  input  alu_op_e   alu_op,
  input  bcu_op_e   bcu_op,
  input  lsu_op_e   lsu_op,
  input  div_op_e   div_op,
  input  logic      flush,
  output logic      busy,
  output logic      res_valid,
  output logic      res_wren,
  output reg_addr_t res_waddr,
  output word_t     res_wdata,
  output logic      res_load,
  output logic      res_store,
  output word_t     res_sdata,
  output word_t     res_address,
  output byte_en_t  res_byte_enable,
  output lsu_op_e   res_lsu_op,
  output logic      res_jump,
  output word_t     res_jump_target,
  output logic      res_exception,
  output cause_t    res_ecause,
  output word_t     res_etval
);

  word_t    alu_a, alu_b, alu_result;
  alu_op_e  alu_fn;
  word_t    bcu_rdata1, bcu_rdata2;
  bcu_op_e  bcu_fn;
  logic     bcu_taken;
  word_t    agu_rdata1, agu_imm, agu_pc, agu_address, agu_etval;
  logic     agu_auipc, agu_jal, agu_jalr, agu_branch, agu_load, agu_store;
  lsu_op_e  agu_lsu_op;
  byte_en_t agu_byte_enable;
  logic     agu_exception;
  cause_t   agu_ecause;
  logic     div_start, div_abort, div_ready;
  div_op_e  div_fn;
  word_t    div_dividend, div_divisor, div_result;

  execute_stage i_stage (.*);

  exec_alu i_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_fn),
    .result (alu_result)
  );

  exec_branch_unit i_bcu (
    .rdata1 (bcu_rdata1),
    .rdata2 (bcu_rdata2),
    .op     (bcu_fn),
    .taken  (bcu_taken)
  );

  exec_agu i_agu (
    .rdata1      (agu_rdata1),
    .imm         (agu_imm),
    .pc          (agu_pc),
    .auipc       (agu_auipc),
    .jalr        (agu_jalr),
    .branch      (agu_branch),
    .jal         (agu_jal),
    .load        (agu_load),
    .store       (agu_store),
    .lsu_op      (agu_lsu_op),
    .address     (agu_address),
    .byte_enable (agu_byte_enable),
    .exception   (agu_exception),
    .ecause      (agu_ecause),
    .etval       (agu_etval)
  );

  exec_divider i_div (
    .clk      (clk),
    .rst      (rst),
    .start    (div_start),
    .abort    (div_abort),
    .op       (div_fn),
    .dividend (div_dividend),
    .divisor  (div_divisor),
    .ready    (div_ready),
    .result   (div_result)
  );

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue,
  input  word_t     pc,
  input  word_t     imm,
  input  word_t     rdata1,
  input  word_t     rdata2,
  input  reg_addr_t waddr,
  input  logic      rden2,
  input  logic      lui,
  input  logic      auipc,
  input  logic      jal,
  input  logic      jalr,
  input  logic      branch,
  input  logic      load,
  input  logic      store,
  input  logic      division,
  input  alu_op_e   alu_op,
  input  bcu_op_e   bcu_op,
  input  lsu_op_e   lsu_op,
  input  div_op_e   div_op,
  input  logic      flush,
  output word_t     alu_a,
  output word_t     alu_b,
  output alu_op_e   alu_fn,
  input  word_t     alu_result,
  output word_t     bcu_rdata1,
  output word_t     bcu_rdata2,
  output bcu_op_e   bcu_fn,
  input  logic      bcu_taken,
  output word_t     agu_rdata1,
  output word_t     agu_imm,
  output word_t     agu_pc,
  output logic      agu_auipc,
  output logic      agu_jal,
  output logic      agu_jalr,
  output logic      agu_branch,
  output logic      agu_load,
  output logic      agu_store,
  output lsu_op_e   agu_lsu_op,
  input  word_t     agu_address,
  input  byte_en_t  agu_byte_enable,
  input  logic      agu_exception,
  input  cause_t    agu_ecause,
  input  word_t     agu_etval,
  output logic      div_start,
  output logic      div_abort,
  output div_op_e   div_fn,
  output word_t     div_dividend,
  output word_t     div_divisor,
  input  logic      div_ready,
  input  word_t     div_result,
  output logic      busy,
  output logic      res_valid,
  output logic      res_wren,
  output reg_addr_t res_waddr,
  output word_t     res_wdata,
  output logic      res_load,
  output logic      res_store,
  output word_t     res_sdata,
  output word_t     res_address,
  output byte_en_t  res_byte_enable,
  output lsu_op_e   res_lsu_op,
  output logic      res_jump,
  output word_t     res_jump_target,
  output logic      res_exception,
  output cause_t    res_ecause,
  output word_t     res_etval
);

  logic      hold;
  word_t     pc_q, imm_q, rdata1_q, rdata2_q;
  reg_addr_t waddr_q;

  logic      live;
  word_t     cur_pc, cur_imm, cur_rdata1, cur_rdata2;
  reg_addr_t cur_waddr;
  logic      cur_lui, cur_auipc, cur_jal, cur_jalr, cur_branch;
  logic      cur_load, cur_store, cur_division;
  logic      jump, exception, kill, commit;
  word_t     wdata;

  // ~~~~~~~~~~~~~~~~~~~~
  // Working copy
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst) begin
      hold <= 1'b0;
    end else begin
      hold <= busy; // Replay the held division on the next cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      pc_q <= pc;
      imm_q <= imm;
      rdata1_q <= rdata1;
      rdata2_q <= rdata2;
      waddr_q <= waddr;
    end
  end

  assign live = issue & ~hold;
  assign cur_pc = hold ? pc_q : pc;
  assign cur_imm = hold ? imm_q : imm;
  assign cur_rdata1 = hold ? rdata1_q : rdata1;
  assign cur_rdata2 = hold ? rdata2_q : rdata2;
  assign cur_waddr = hold ? waddr_q : waddr;
  assign cur_lui = live & lui;
  assign cur_auipc = live & auipc;
  assign cur_jal = live & jal;
  assign cur_jalr = live & jalr;
  assign cur_branch = live & branch;
  assign cur_load = live & load;
  assign cur_store = live & store;
  assign cur_division = hold | (live & division);

  // ~~~~~~~~~~~~~~~~~~~~
  // Unit steering
  // ~~~~~~~~~~~~~~~~~~~~

  assign alu_a = cur_rdata1;
  assign alu_b = rden2 ? cur_rdata2 : cur_imm; // rden2 high selects the register.
  assign alu_fn = alu_op;
  assign bcu_rdata1 = cur_rdata1;
  assign bcu_rdata2 = cur_rdata2;
  assign bcu_fn = bcu_op;
  assign agu_rdata1 = cur_rdata1;
  assign agu_imm = cur_imm;
  assign agu_pc = cur_pc;
  assign agu_auipc = cur_auipc;
  assign agu_jal = cur_jal;
  assign agu_jalr = cur_jalr;
  assign agu_branch = cur_branch;
  assign agu_load = cur_load;
  assign agu_store = cur_store;
  assign agu_lsu_op = lsu_op;
  assign div_start = live & division & ~flush;
  assign div_abort = flush;
  assign div_fn = div_op;
  assign div_dividend = cur_rdata1;
  assign div_divisor = cur_rdata2;

  assign busy = cur_division & ~div_ready & ~flush;

  always_comb begin
    if (cur_auipc) begin
      wdata = agu_address;
    end else if (cur_lui) begin
      wdata = cur_imm;
    end else if (cur_jal | cur_jalr) begin
      wdata = cur_pc + 32'd4;
    end else if (cur_division) begin
      wdata = div_result;
    end else begin
      wdata = alu_result;
    end
  end

  assign jump = cur_jal | cur_jalr | (cur_branch & bcu_taken);
  assign exception = agu_exception & ~(cur_branch & ~bcu_taken); // A fall-through has no target.
  assign kill = ~(live | hold) | flush | busy;
  assign commit = ~kill & ~exception;

  // ~~~~~~~~~~~~~~~~~~~~
  // Result register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst) begin
      res_valid <= 1'b0;
      res_wren <= 1'b0;
      res_load <= 1'b0;
      res_store <= 1'b0;
      res_jump <= 1'b0;
      res_exception <= 1'b0;
    end else begin
      res_valid <= ~kill;
      res_wren <= commit & (|cur_waddr);
      res_load <= commit & cur_load;
      res_store <= commit & cur_store;
      res_jump <= commit & jump;
      res_exception <= ~kill & exception;
    end
  end

  always_ff @(posedge clk) begin
    res_waddr <= cur_waddr;
    res_wdata <= wdata;
    res_sdata <= cur_rdata2;
    res_address <= agu_address;
    res_byte_enable <= agu_byte_enable;
    res_lsu_op <= lsu_op;
    res_jump_target <= agu_address;
    res_ecause <= agu_ecause;
    res_etval <= agu_etval;
  end

  a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst) busy |=> !issue)
    else $error("Instruction issued while the stage was busy.");

endmodule

//--- verif/exec_tb.sv
`timescale 1ns/1ps

module exec_tb
  import exec_pkg::*;
();

  typedef struct {
    logic      wren;
    logic      load;
    logic      store;
    logic      jump;
    logic      exc;
    logic      chk_wdata;
    logic      chk_mem;
    reg_addr_t waddr;
    word_t     wdata;
    word_t     sdata;
    word_t     address;
    byte_en_t  be;
    logic [2:0] lsu;
    word_t     target;
    cause_t    ecause;
    word_t     etval;
  } exp_t;

  logic      clk, rst, issue, flush, rden2;
  logic      lui, auipc, jal, jalr, branch, load, store, division;
  word_t     pc, imm, rdata1, rdata2;
  reg_addr_t waddr;
  alu_op_e   alu_op;
  bcu_op_e   bcu_op;
  lsu_op_e   lsu_op;
  div_op_e   div_op;

  logic      busy, res_valid, res_wren, res_load, res_store, res_jump, res_exception;
  reg_addr_t res_waddr;
  word_t     res_wdata, res_sdata, res_address, res_jump_target, res_etval;
  byte_en_t  res_byte_enable;
  lsu_op_e   res_lsu_op;
  cause_t    res_ecause;

  exp_t        exp_q[$];
  exp_t        head;
  logic        head_ok = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  string       test_name = "reset";
  logic [31:0] lfsr = 32'd45;
  bcu_op_e     bcu_ops[6] = '{bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu};

  exec_top i_dut (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32, 22, 2, 1.
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t alu_ref(input word_t a, input word_t b, input alu_op_e op);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return word_t'($signed(a) >>> b[4:0]);
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input word_t a, input word_t b, input bcu_op_e op);
    case (op)
      bcu_beq:  return a == b;
      bcu_bne:  return a != b;
      bcu_blt:  return $signed(a) < $signed(b);
      bcu_bge:  return $signed(a) >= $signed(b);
      bcu_bltu: return a < b;
      default:  return a >= b;
    endcase
  endfunction

  function automatic word_t div_ref(input word_t a, input word_t b, input div_op_e op);
    word_t q;
    word_t r;
    if (b == 32'd0) begin
      q = '1;
      r = a;
    end else if (op == div_divu || op == div_remu) begin
      q = a / b;
      r = a % b;
    end else if (a == 32'h8000_0000 && b == '1) begin
      q = a; // Signed overflow.
      r = '0;
    end else begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end
    return (op == div_rem || op == div_remu) ? r : q;
  endfunction

  function automatic byte_en_t be_ref(input word_t a, input lsu_op_e op);
    if (op == lsu_lb || op == lsu_lbu || op == lsu_sb) return byte_en_t'(1 << a[1:0]);
    if (op == lsu_lh || op == lsu_lhu || op == lsu_sh) return a[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic logic misaligned_ref(input word_t a, input lsu_op_e op);
    if (op == lsu_lb || op == lsu_lbu || op == lsu_sb) return 1'b0;
    if (op == lsu_lh || op == lsu_lhu || op == lsu_sh) return a[0];
    return a[1:0] != 2'b00;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Checking
  // ~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    head_ok = 1'b0;
    if (rst && res_valid) begin
      head_ok = exp_q.size() > 0; // Compared at the next rising edge.
      if (head_ok) head = exp_q.pop_front();
      checks++;
    end
  end

  a_expected: assert property (@(posedge clk) disable iff (!rst) res_valid |-> head_ok)
    else begin
      errors++;
      $display("%s: a result appeared that no instruction should have produced", test_name);
    end

  a_idle_ctrl: assert property (@(posedge clk) disable iff (!rst)
      !res_valid |-> !(res_wren | res_load | res_store | res_jump | res_exception))
    else begin
      errors++;
      $display("%s: a control output was high without a valid result", test_name);
    end

  a_waddr: assert property (@(posedge clk) disable iff (!rst)
      res_valid && head_ok |-> res_waddr == head.waddr)
    else begin
      errors++;
      $display("Fail %s waddr: expected %0d, actual %0d", test_name, head.waddr,
               $sampled(res_waddr));
    end

  a_wdata: assert property (@(posedge clk) disable iff (!rst)
      res_valid && head_ok && head.chk_wdata |-> res_wdata == head.wdata)
    else begin
      errors++;
      $display("Fail %s wdata: expected %h, actual %h", test_name, head.wdata,
               $sampled(res_wdata));
    end

  a_flags: assert property (@(posedge clk) disable iff (!rst) res_valid && head_ok |->
      {res_wren, res_load, res_store, res_jump, res_exception} ==
      {head.wren, head.load, head.store, head.jump, head.exc})
    else begin
      errors++;
      $display("Fail %s wren/load/store/jump/exception: expected %b, actual %b", test_name,
               {head.wren, head.load, head.store, head.jump, head.exc},
               $sampled({res_wren, res_load, res_store, res_jump, res_exception}));
    end

  a_mem: assert property (@(posedge clk) disable iff (!rst) res_valid && head_ok && head.chk_mem
      |-> {res_address, res_byte_enable, res_sdata, res_lsu_op} ==
      {head.address, head.be, head.sdata, head.lsu})
    else begin
      errors++;
      $display("Fail %s address/be/sdata/lsu_op: expected %h %h %h %h, actual %h %h %h %h",
               test_name, head.address, head.be, head.sdata, head.lsu,
               $sampled(res_address), $sampled(res_byte_enable), $sampled(res_sdata),
               $sampled(res_lsu_op));
    end

  a_target: assert property (@(posedge clk) disable iff (!rst)
      res_valid && head_ok && head.jump |-> res_jump_target == head.target)
    else begin
      errors++;
      $display("Fail %s jump_target: expected %h, actual %h", test_name, head.target,
               $sampled(res_jump_target));
    end

  a_cause: assert property (@(posedge clk) disable iff (!rst) res_valid && head_ok && head.exc
      |-> {res_ecause, res_etval} == {head.ecause, head.etval})
    else begin
      errors++;
      $display("Fail %s ecause/etval: expected %h %h, actual %h %h", test_name, head.ecause,
               head.etval, $sampled(res_ecause), $sampled(res_etval));
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst)
      issue && !division && !flush |=> res_valid)
    else begin
      errors++;
      $display("%s: result did not appear one cycle after issue", test_name);
    end

  a_busy_end: assert property (@(posedge clk) disable iff (!rst)
      $fell(busy) && !flush |=> res_valid)
    else begin
      errors++;
      $display("%s: busy dropped without a division result", test_name);
    end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic clear_fields();
    {lui, auipc, jal, jalr, branch, load, store, division} = '0;
    rden2 = 1'b1;
    waddr = '0;
    alu_op = alu_add;
    bcu_op = bcu_beq;
    lsu_op = lsu_lw;
    div_op = div_div;
  endtask

  task automatic send(input exp_t e, input logic expect_result);
    if (expect_result) exp_q.push_back(e);
    issue = 1'b1;
    @(posedge clk);
    #1;
    issue = 1'b0;
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (busy) begin
      errors++;
      $display("%s: busy stayed high for 100 cycles", test_name);
    end
    @(posedge clk); // Lets the held division leave the stage.
    #1;
  endtask

  task automatic finish_test();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("%s: %0d results missing after 100 cycles", test_name, exp_q.size());
      exp_q.delete();
    end
    repeat (2) @(posedge clk);
    #1;
    tests++;
    $display("%s finished, %0d errors so far", test_name, errors);
  endtask

  initial begin
    exp_t  e;
    word_t t;
    logic  st;
    logic  mis;
    clear_fields();
    {issue, flush, rst} = '0;
    {pc, imm, rdata1, rdata2} = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;

    test_name = "alu";
    for (int i = 0; i < 200; i++) begin
      clear_fields();
      rdata1 = rand_bits(32);
      rdata2 = rand_bits(32);
      imm = sext12(rand_bits(12));
      rden2 = rand_bits(1);
      alu_op = alu_op_e'(4'(rand_bits(4) % 10));
      waddr = (rand_bits(2) == 0) ? 5'd0 : rand_bits(5); // Zero now and then.
      e = '{default: '0};
      e.waddr = waddr;
      e.wren = waddr != 0;
      e.chk_wdata = 1'b1;
      e.wdata = alu_ref(rdata1, rden2 ? rdata2 : imm, alu_op);
      send(e, 1'b1);
    end
    finish_test();

    test_name = "control";
    for (int i = 0; i < 120; i++) begin
      clear_fields();
      pc = rand_bits(32) & ~32'd3;
      rdata1 = rand_bits(32);
      rdata2 = (rand_bits(2) == 0) ? rdata1 : rand_bits(32);
      waddr = rand_bits(5);
      e = '{default: '0};
      case (i % 6)
        0: begin
          lui = 1'b1;
          imm = rand_bits(32) & 32'hFFFF_F000;
          e.wdata = imm;
        end
        1: begin
          auipc = 1'b1;
          imm = rand_bits(32) & 32'hFFFF_F000;
          e.wdata = pc + imm;
        end
        2, 3: begin
          jal = (i % 6) == 2;
          jalr = (i % 6) == 3;
          imm = sext12(rand_bits(12)) & ~32'd1;
          t = jal ? pc + imm : (rdata1 + imm) & ~32'd1;
          e.exc = t[1];
          e.jump = !e.exc;
          e.target = t;
          e.etval = t;
          e.ecause = cause_inst_misaligned;
          e.wdata = pc + 32'd4;
        end
        default: begin
          branch = 1'b1;
          waddr = '0;
          bcu_op = bcu_ops[rand_bits(3) % 6];
          imm = sext12(rand_bits(12)) & ~32'd1;
          t = pc + imm;
          e.exc = branch_ref(rdata1, rdata2, bcu_op) && t[1]; // Only a taken branch traps.
          e.jump = branch_ref(rdata1, rdata2, bcu_op) && !e.exc;
          e.target = t;
          e.etval = t;
          e.ecause = cause_inst_misaligned;
        end
      endcase
      e.waddr = waddr;
      e.wren = !e.exc && waddr != 0;
      e.chk_wdata = !e.exc && !branch;
      send(e, 1'b1);
    end
    finish_test();

    test_name = "memory";
    for (int i = 0; i < 100; i++) begin
      clear_fields();
      lsu_op = lsu_op_e'(rand_bits(3));
      st = lsu_op >= lsu_sb;
      load = !st;
      store = st;
      rdata1 = rand_bits(32);
      rdata2 = rand_bits(32);
      imm = sext12(rand_bits(12));
      waddr = st ? 5'd0 : rand_bits(5);
      t = rdata1 + imm;
      mis = misaligned_ref(t, lsu_op);
      e = '{default: '0};
      e.waddr = waddr;
      e.load = !st && !mis;
      e.store = st && !mis;
      e.wren = !st && !mis && waddr != 0;
      e.exc = mis;
      e.ecause = st ? cause_store_misaligned : cause_load_misaligned;
      e.etval = t;
      e.chk_mem = !mis;
      e.address = t;
      e.be = be_ref(t, lsu_op);
      e.lsu = lsu_op;
      e.sdata = rdata2;
      send(e, 1'b1);
    end
    finish_test();

    test_name = "division";
    for (int i = 0; i < 24; i++) begin
      clear_fields();
      division = 1'b1;
      div_op = div_op_e'(i % 4);
      rdata1 = rand_bits(32);
      rdata2 = (i % 8 < 4) ? rand_bits(32) : rand_bits(32) >> rand_bits(5);
      if (i < 4) rdata2 = '0;
      if (i == 4 || i == 6) begin
        rdata1 = 32'h8000_0000;
        rdata2 = '1;
      end
      waddr = rand_bits(5);
      e = '{default: '0};
      e.waddr = waddr;
      e.wren = waddr != 0;
      e.chk_wdata = 1'b1;
      e.wdata = div_ref(rdata1, rdata2, div_op);
      send(e, 1'b1);
      wait_not_busy();
    end
    finish_test();

    test_name = "flush";
    clear_fields();
    rdata1 = rand_bits(32);
    imm = rand_bits(32);
    waddr = 5'd3;
    flush = 1'b1;
    send(e, 1'b0);
    flush = 1'b0;
    division = 1'b1;
    rdata1 = rand_bits(32);
    rdata2 = rand_bits(16);
    send(e, 1'b0);
    clear_fields();
    repeat (10) @(posedge clk);
    #1;
    flush = 1'b1;
    #1;
    a_flush_busy: assert (!busy)
      else begin
        errors++;
        $display("%s: busy stayed high during a flush", test_name);
      end
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(posedge clk);
    #1;
    division = 1'b1;
    div_op = div_remu;
    waddr = 5'd9;
    e = '{default: '0};
    e.waddr = 5'd9;
    e.wren = 1'b1;
    e.chk_wdata = 1'b1;
    e.wdata = div_ref(rdata1, rdata2, div_remu);
    send(e, 1'b1);
    wait_not_busy();
    finish_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
design/exec_pkg.sv
design/exec_alu.sv
design/exec_branch_unit.sv
design/exec_agu.sv
design/exec_divider.sv
design/execute_stage.sv
design/exec_top.sv
verif/exec_tb.sv
